// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_hierarchy \
		-f mem_hierarchy.f -Mdir obj_dir -o sim_mem_hierarchy

run: compile
	./obj_dir/sim_mem_hierarchy

clean:
	rm -rf obj_dir

// ==== l1_arbiter.sv ====
`timescale 1ns/1ns

module l1_arbiter
        import rv32i_types::*;
(
        input logic clk,
        input logic reset,

        // icache
        input line_req_t req_i,
        output line_rsp_t rsp_i,

        // dcache
        input line_req_t req_d,
        output line_rsp_t rsp_d,

        // physical memory
        output line_req_t pmem_req,
        input line_rsp_t pmem_rsp
);

arb_state_e state;

logic pending_i;
logic pending_d;
logic done;

assign pending_i = req_i.read || req_i.write;
assign pending_d = req_d.read || req_d.write;
assign done = pmem_rsp.resp && state != arb_idle;

// grant taken only from idle, dcache first
always_ff @(posedge clk) begin
        if (reset) begin
                state <= arb_idle;
        end else begin
                case (state)
                arb_idle: begin
                        if (pending_d) begin
                                state <= grant_d;
                        end else if (pending_i) begin
                                state <= grant_i;
                        end
                end
                grant_i, grant_d: begin
                        if (done) begin
                                state <= arb_idle;
                        end
                end
                default: begin
                        state <= arb_idle;
                end
                endcase
        end
end

// route the grantee only
always_comb begin
        case (state)
        grant_i: pmem_req = req_i;
        grant_d: pmem_req = req_d;
        default: pmem_req = '0;
        endcase
end

// read data is shared, resp goes to the grantee
always_comb begin
        rsp_i.rdata = pmem_rsp.rdata;
        rsp_d.rdata = pmem_rsp.rdata;
        rsp_i.resp = pmem_rsp.resp && state == grant_i;
        rsp_d.resp = pmem_rsp.resp && state == grant_d;
end

endmodule : l1_arbiter

// ==== l1_cache.sv ====
`timescale 1ns/1ns

module l1_cache
        import rv32i_types::*;
#(
        parameter int s_index = 3
)
(
        input logic clk,
        input logic reset,

        // core side
        input core_req_t core_req,
        output core_rsp_t core_rsp,

        // line side, toward the arbiter
        output line_req_t mem_req,
        input line_rsp_t mem_rsp,

        // event pulses for the counters
        output logic hit,
        output logic miss
);

localparam int s_tag = 32 - s_index - s_offset;
localparam int num_sets = 2 ** s_index;

cache_state_e state;

// storage
logic [s_tag-1:0] tag_array [num_sets];
line_t line_array [num_sets];
logic [num_sets-1:0] valid_array;
logic [num_sets-1:0] dirty_array;

// address fields
logic [s_tag-1:0] req_tag;
logic [s_index-1:0] req_index;
logic [2:0] req_word;

logic access;
logic tag_match;
logic resp_q;
rv32i_word rdata_q;
line_t cur_line;
line_t hit_line;
line_t fill_line;
logic [3:0] fill_mask;

// replace the masked bytes of one word in a line
function automatic line_t merge_word(input line_t line, input logic [2:0] word,
                                     input logic [3:0] wmask, input rv32i_word wdata);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                        merged[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
                end
        end
        return merged;
endfunction

assign req_tag = core_req.addr[31 -: s_tag];
assign req_index = core_req.addr[s_offset +: s_index];
assign req_word = core_req.addr[4:2];

assign cur_line = line_array[req_index];

// a held request is checked once, not again in its resp cycle
assign access = (core_req.read || core_req.write) && !resp_q && state == cache_idle;
assign tag_match = valid_array[req_index] && tag_array[req_index] == req_tag;
assign hit = access && tag_match;
assign miss = access && !tag_match;

assign hit_line = merge_word(cur_line, req_word, core_req.wmask, core_req.wdata);

// on a write miss the store lands in the fresh line directly
assign fill_mask = core_req.write ? core_req.wmask : 4'b0000;
assign fill_line = merge_word(mem_rsp.rdata, req_word, fill_mask, core_req.wdata);

assign core_rsp = '{resp: resp_q, rdata: rdata_q};

// control state
always_ff @(posedge clk) begin
        if (reset) begin
                state <= cache_idle;
                resp_q <= 1'b0;
                valid_array <= '0;
                dirty_array <= '0;
        end else begin
                resp_q <= 1'b0;
                case (state)
                cache_idle: begin
                        if (hit) begin
                                resp_q <= 1'b1;
                                if (core_req.write) begin
                                        dirty_array[req_index] <= 1'b1;
                                end
                        end else if (miss) begin
                                if (valid_array[req_index] && dirty_array[req_index]) begin
                                        state <= cache_writeback;
                                end else begin
                                        state <= cache_fill;
                                end
                        end
                end
                cache_writeback: begin
                        if (mem_rsp.resp) begin
                                dirty_array[req_index] <= 1'b0;
                                state <= cache_fill;
                        end
                end
                cache_fill: begin
                        if (mem_rsp.resp) begin
                                valid_array[req_index] <= 1'b1;
                                dirty_array[req_index] <= core_req.write;
                                resp_q <= 1'b1;
                                state <= cache_idle;
                        end
                end
                default: begin
                        state <= cache_idle;
                end
                endcase
        end
end

// tags, lines and read data
always_ff @(posedge clk) begin
        if (hit) begin
                rdata_q <= cur_line[req_word*32 +: 32];
                if (core_req.write) begin
                        line_array[req_index] <= hit_line;
                end
        end
        if (state == cache_fill && mem_rsp.resp) begin
                tag_array[req_index] <= req_tag;
                line_array[req_index] <= fill_line;
                rdata_q <= mem_rsp.rdata[req_word*32 +: 32];
        end
end

// line request toward the arbiter
always_comb begin
        mem_req = '0;
        case (state)
        cache_writeback: begin
                mem_req.write = 1'b1;
                mem_req.addr = {tag_array[req_index], req_index, {s_offset{1'b0}}};
                mem_req.wdata = cur_line;
        end
        cache_fill: begin
                mem_req.read = 1'b1;
                mem_req.addr = {req_tag, req_index, {s_offset{1'b0}}};
        end
        default: begin
                mem_req = '0;
        end
        endcase
end

endmodule : l1_cache

// ==== mem_hierarchy.f ====
rv32i_types.sv
l1_cache.sv
l1_arbiter.sv
perf_counter.sv
mem_hierarchy.sv
pmem_model.sv
mem_hierarchy_sva.sv
tb_mem_hierarchy.sv

// ==== mem_hierarchy.sv ====
`timescale 1ns/1ns

module mem_hierarchy
        import rv32i_types::*;
#(
        parameter int s_index = 3
)
(
        input logic clk,
        input logic reset,

        // port A, instruction fetch
        input core_req_t req_a,
        output core_rsp_t rsp_a,

        // port B, loads and stores
        input core_req_t req_b,
        output core_rsp_t rsp_b,

        // physical memory
        output line_req_t pmem_req,
        input line_rsp_t pmem_rsp,

        input rv32i_word branch_total_count,
        input rv32i_word branch_correct_count,
        input rv32i_word branch_incorrect_count,
        output logic branch_total_reset,
        output logic branch_correct_reset,
        output logic branch_incorrect_reset
);

core_req_t icache_req;
core_req_t dcache_req;
core_rsp_t dcache_rsp;
line_req_t icache_line_req;
line_rsp_t icache_line_rsp;
line_req_t dcache_line_req;
line_rsp_t dcache_line_rsp;
logic icache_hit;
logic icache_miss;
logic dcache_hit;
logic dcache_miss;

// instruction side never writes
always_comb begin
        icache_req = req_a;
        icache_req.write = 1'b0;
end

perf_counter counter
(
        .clk,
        .reset,
        .core_req(req_b),
        .core_rsp(rsp_b),
        .cache_req(dcache_req),
        .cache_rsp(dcache_rsp),
        .icache_hit,
        .icache_miss,
        .dcache_hit,
        .dcache_miss,
        .branch_total_count,
        .branch_correct_count,
        .branch_incorrect_count,
        .branch_total_reset,
        .branch_correct_reset,
        .branch_incorrect_reset
);

l1_cache #(.s_index(s_index)) icache
(
        .clk,
        .reset,
        .core_req(icache_req),
        .core_rsp(rsp_a),
        .mem_req(icache_line_req),
        .mem_rsp(icache_line_rsp),
        .hit(icache_hit),
        .miss(icache_miss)
);

l1_cache #(.s_index(s_index)) dcache
(
        .clk,
        .reset,
        .core_req(dcache_req),
        .core_rsp(dcache_rsp),
        .mem_req(dcache_line_req),
        .mem_rsp(dcache_line_rsp),
        .hit(dcache_hit),
        .miss(dcache_miss)
);

l1_arbiter arbiter
(
        .clk,
        .reset,
        .req_i(icache_line_req),
        .rsp_i(icache_line_rsp),
        .req_d(dcache_line_req),
        .rsp_d(dcache_line_rsp),
        .pmem_req,
        .pmem_rsp
);

endmodule : mem_hierarchy

// ==== mem_hierarchy_sva.sv ====
`timescale 1ns/1ns

module mem_hierarchy_sva
        import rv32i_types::*;
(
        input logic clk,
        input logic reset,
        input core_req_t req_a,
        input core_rsp_t rsp_a,
        input line_req_t pmem_req,
        input line_rsp_t pmem_rsp,
        input logic branch_total_reset,
        input logic branch_correct_reset,
        input logic branch_incorrect_reset
);

resp_a_needs_request: assert property (@(posedge clk) disable iff (reset)
        rsp_a.resp |-> (req_a.read || req_a.write))
        else $error("port A resp without a held request");

pmem_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pmem_req.read && pmem_req.write))
        else $error("pmem read and write high together");

// reset pulses are single cycle
total_reset_pulse: assert property (@(posedge clk) disable iff (reset)
        branch_total_reset |=> !branch_total_reset)
        else $error("branch_total_reset longer than one cycle");

correct_reset_pulse: assert property (@(posedge clk) disable iff (reset)
        branch_correct_reset |=> !branch_correct_reset)
        else $error("branch_correct_reset longer than one cycle");

incorrect_reset_pulse: assert property (@(posedge clk) disable iff (reset)
        branch_incorrect_reset |=> !branch_incorrect_reset)
        else $error("branch_incorrect_reset longer than one cycle");

pmem_req_stable: assert property (@(posedge clk) disable iff (reset)
        (pmem_req.read || pmem_req.write) && !pmem_rsp.resp |=> $stable(pmem_req))
        else $error("pmem request changed before resp");

endmodule : mem_hierarchy_sva

bind mem_hierarchy mem_hierarchy_sva u_sva (
        .clk(clk),
        .reset(reset),
        .req_a(req_a),
        .rsp_a(rsp_a),
        .pmem_req(pmem_req),
        .pmem_rsp(pmem_rsp),
        .branch_total_reset(branch_total_reset),
        .branch_correct_reset(branch_correct_reset),
        .branch_incorrect_reset(branch_incorrect_reset)
);

// ==== perf_counter.sv ====
`timescale 1ns/1ns

module perf_counter
        import rv32i_types::*;
(
        input logic clk,
        input logic reset,

        // port B in, dcache out
        input core_req_t core_req,
        output core_rsp_t core_rsp,
        output core_req_t cache_req,
        input core_rsp_t cache_rsp,

        // cache events
        input logic icache_hit,
        input logic icache_miss,
        input logic dcache_hit,
        input logic dcache_miss,

        // branch counts kept outside
        input rv32i_word branch_total_count,
        input rv32i_word branch_correct_count,
        input rv32i_word branch_incorrect_count,
        output logic branch_total_reset,
        output logic branch_correct_reset,
        output logic branch_incorrect_reset
);

perf_sel_e sel;
logic in_window;
logic access;
logic clear;
logic [3:0] events;
rv32i_word event_count [4];
rv32i_word sel_data;
logic resp_q;
rv32i_word rdata_q;

assign in_window = core_req.addr[31:16] == perf_base;
assign sel = perf_sel_e'(core_req.addr[4:2]);
assign access = (core_req.read || core_req.write) && in_window && !resp_q;
assign clear = access && core_req.write;

// bit order follows perf_sel_e
assign events = {dcache_miss, dcache_hit, icache_miss, icache_hit};

// window accesses never reach the dcache
always_comb begin
        cache_req = core_req;
        cache_req.read = core_req.read && !in_window;
        cache_req.write = core_req.write && !in_window;
end

always_comb begin
        case (sel)
        perf_icache_hit: sel_data = event_count[0];
        perf_icache_miss: sel_data = event_count[1];
        perf_dcache_hit: sel_data = event_count[2];
        perf_dcache_miss: sel_data = event_count[3];
        perf_branch_total: sel_data = branch_total_count;
        perf_branch_correct: sel_data = branch_correct_count;
        perf_branch_incorrect: sel_data = branch_incorrect_count;
        default: sel_data = '0;
        endcase
end

always_ff @(posedge clk) begin
        if (reset) begin
                resp_q <= 1'b0;
                branch_total_reset <= 1'b0;
                branch_correct_reset <= 1'b0;
                branch_incorrect_reset <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                        event_count[i] <= '0;
                end
        end else begin
                resp_q <= access;
                branch_total_reset <= clear && sel == perf_branch_total;
                branch_correct_reset <= clear && sel == perf_branch_correct;
                branch_incorrect_reset <= clear && sel == perf_branch_incorrect;
                // a clear wins over an event in the same cycle
                for (int i = 0; i < 4; i++) begin
                        if (clear && sel == perf_sel_e'(i)) begin
                                event_count[i] <= '0;
                        end else if (events[i]) begin
                                event_count[i] <= event_count[i] + 1'b1;
                        end
                end
        end
end

always_ff @(posedge clk) begin
        if (access) begin
                rdata_q <= sel_data;
        end
end

assign core_rsp.resp = resp_q || cache_rsp.resp;
assign core_rsp.rdata = resp_q ? rdata_q : cache_rsp.rdata;

endmodule : perf_counter

// ==== pmem_model.sv ====
`timescale 1ns/1ns

module pmem_model
        import rv32i_types::*;
#(
        parameter rv32i_word fill_key = 32'h0000_0000
)
(
        input logic clk,
        input logic reset,
        input line_req_t req,
        output line_rsp_t rsp
);

// only written lines are kept, the rest follow the fill rule
line_t lines [logic [26:0]];
integer seed;
int unsigned wait_count;
logic busy;

initial begin
        seed = 32'h3383_3b12;
end

function automatic line_t read_line(input rv32i_word addr);
        line_t line;
        rv32i_word word_addr;
        if (lines.exists(addr[31:5])) begin
                return lines[addr[31:5]];
        end
        for (int w = 0; w < 8; w++) begin
                word_addr = {addr[31:5], 5'b00000} + 32'(w * 4);
                line[w*32 +: 32] = word_addr ^ fill_key;
        end
        return line;
endfunction

always @(posedge clk) begin
        if (reset) begin
                busy <= 1'b0;
                wait_count <= 0;
                rsp <= '0;
        end else begin
                rsp.resp <= 1'b0;
                if (!busy) begin
                        // the request is still held in its resp cycle
                        if ((req.read || req.write) && !rsp.resp) begin
                                busy <= 1'b1;
                                wait_count <= 2 + ($unsigned($random(seed)) % 5);
                        end
                end else if (wait_count > 1) begin
                        wait_count <= wait_count - 1;
                end else begin
                        busy <= 1'b0;
                        rsp.resp <= 1'b1;
                        if (req.write) begin
                                lines[req.addr[31:5]] = req.wdata;
                        end else begin
                                rsp.rdata <= read_line(req.addr);
                        end
                end
        end
end

endmodule : pmem_model

// ==== rv32i_types.sv ====
package rv32i_types;

typedef logic [31:0] rv32i_word;
typedef logic [255:0] line_t;

// byte offset bits within a 256-bit line
localparam int s_offset = 5;

// upper address half of the counter window
localparam logic [15:0] perf_base = 16'hFFFF;

typedef struct packed {
        logic read;
        logic write;
        rv32i_word addr;
        logic [3:0] wmask;
        rv32i_word wdata;
} core_req_t;

typedef struct packed {
        logic resp;
        rv32i_word rdata;
} core_rsp_t;

typedef struct packed {
        logic read;
        logic write;
        rv32i_word addr;
        line_t wdata;
} line_req_t;

typedef struct packed {
        logic resp;
        line_t rdata;
} line_rsp_t;

typedef enum logic [1:0] {
        cache_idle,
        cache_writeback,
        cache_fill
} cache_state_e;

typedef enum logic [1:0] {
        arb_idle,
        grant_i,
        grant_d
} arb_state_e;

// word offsets in the counter window
typedef enum logic [2:0] {
        perf_icache_hit,
        perf_icache_miss,
        perf_dcache_hit,
        perf_dcache_miss,
        perf_branch_total,
        perf_branch_correct,
        perf_branch_incorrect
} perf_sel_e;

endpackage : rv32i_types

// ==== tb_mem_hierarchy.sv ====
`timescale 1ns/1ns

module tb_mem_hierarchy
        import rv32i_types::*;
;

localparam int s_index = 3;
localparam rv32i_word fill_key = 32'h5a3c_96e1;
localparam int timeout = 200;

logic clk;
logic reset;
core_req_t req_a;
core_rsp_t rsp_a;
core_req_t req_b;
core_rsp_t rsp_b;
line_req_t pmem_req;
line_rsp_t pmem_rsp;
rv32i_word branch_total_count;
rv32i_word branch_correct_count;
rv32i_word branch_incorrect_count;
logic branch_total_reset;
logic branch_correct_reset;
logic branch_incorrect_reset;

integer seed;
int total_pulses = 0;
int correct_pulses = 0;
int incorrect_pulses = 0;

// unwritten reference words follow the fill rule
rv32i_word ref_mem [rv32i_word];

mem_hierarchy #(.s_index(s_index)) u_dut (
        .clk,
        .reset,
        .req_a,
        .rsp_a,
        .req_b,
        .rsp_b,
        .pmem_req,
        .pmem_rsp,
        .branch_total_count,
        .branch_correct_count,
        .branch_incorrect_count,
        .branch_total_reset,
        .branch_correct_reset,
        .branch_incorrect_reset
);

pmem_model #(.fill_key(fill_key)) u_pmem (
        .clk,
        .reset,
        .req(pmem_req),
        .rsp(pmem_rsp)
);

initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
end

// mid-cycle count of the branch reset pulses
always @(negedge clk) begin
        if (!reset && branch_total_reset) begin
                total_pulses++;
        end
        if (!reset && branch_correct_reset) begin
                correct_pulses++;
        end
        if (!reset && branch_incorrect_reset) begin
                incorrect_pulses++;
        end
end

task automatic report_fail(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
endtask

task automatic check_word(input string name, input rv32i_word expected, input rv32i_word actual);
        assert (actual === expected)
        else report_fail($sformatf("FAIL %s: expected 0x%08h, got 0x%08h", name, expected, actual));
endtask

function automatic rv32i_word ref_read(input rv32i_word addr);
        rv32i_word key;
        key = {addr[31:2], 2'b00};
        if (ref_mem.exists(key)) begin
                return ref_mem[key];
        end
        return key ^ fill_key;
endfunction

function automatic void ref_write(input rv32i_word addr, input logic [3:0] wmask,
                                  input rv32i_word wdata);
        rv32i_word word;
        word = ref_read(addr);
        for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                        word[b*8 +: 8] = wdata[b*8 +: 8];
                end
        end
        ref_mem[{addr[31:2], 2'b00}] = word;
endfunction

function automatic rv32i_word window_addr(input perf_sel_e sel);
        return {perf_base, 11'b0, sel, 2'b00};
endfunction

task automatic fetch_word(input rv32i_word addr, output rv32i_word rdata);
        int cycles;
        @(posedge clk);
        #1;
        req_a = '0;
        req_a.read = 1'b1;
        req_a.addr = addr;
        cycles = 0;
        do begin
                @(posedge clk);
                #1;
                cycles++;
        end while (!rsp_a.resp && cycles < timeout);
        assert (rsp_a.resp)
        else report_fail($sformatf("port A fetch at 0x%08h got no response", addr));
        rdata = rsp_a.rdata;
        // hold through the resp cycle
        @(posedge clk);
        #1;
        req_a = '0;
endtask

task automatic data_access(input logic write, input rv32i_word addr, input logic [3:0] wmask,
                           input rv32i_word wdata, output rv32i_word rdata);
        int cycles;
        @(posedge clk);
        #1;
        req_b.read = !write;
        req_b.write = write;
        req_b.addr = addr;
        req_b.wmask = wmask;
        req_b.wdata = wdata;
        cycles = 0;
        do begin
                @(posedge clk);
                #1;
                cycles++;
        end while (!rsp_b.resp && cycles < timeout);
        assert (rsp_b.resp)
        else report_fail($sformatf("port B access at 0x%08h got no response", addr));
        rdata = rsp_b.rdata;
        @(posedge clk);
        #1;
        req_b = '0;
endtask

task automatic fetch_hit_after_miss();
        rv32i_word data;
        fetch_word(32'h0000_0044, data);
        check_word("rsp_a.rdata", ref_read(32'h0000_0044), data);
        fetch_word(32'h0000_0044, data);
        check_word("rsp_a.rdata", ref_read(32'h0000_0044), data);
        data_access(1'b0, window_addr(perf_icache_hit), 4'h0, '0, data);
        check_word("icache_hit count", 32'd1, data);
        data_access(1'b0, window_addr(perf_icache_miss), 4'h0, '0, data);
        check_word("icache_miss count", 32'd1, data);
endtask

task automatic masked_store_readback();
        rv32i_word data;
        data_access(1'b1, 32'h0000_0104, 4'b0101, 32'haabb_ccdd, data);
        ref_write(32'h0000_0104, 4'b0101, 32'haabb_ccdd);
        data_access(1'b0, 32'h0000_0104, 4'h0, '0, data);
        check_word("rsp_b.rdata", ref_read(32'h0000_0104), data);
endtask

// same index but different tags
task automatic evict_dirty_line();
        rv32i_word data;
        rv32i_word first;
        rv32i_word second;
        first = $random(seed);
        second = $random(seed);
        data_access(1'b1, 32'h0000_1048, 4'hf, first, data);
        ref_write(32'h0000_1048, 4'hf, first);
        data_access(1'b1, 32'h0000_2048, 4'hf, second, data);
        ref_write(32'h0000_2048, 4'hf, second);
        data_access(1'b0, 32'h0000_1048, 4'h0, '0, data);
        check_word("rsp_b.rdata", ref_read(32'h0000_1048), data);
        data_access(1'b0, 32'h0000_2048, 4'h0, '0, data);
        check_word("rsp_b.rdata", ref_read(32'h0000_2048), data);
endtask

task automatic concurrent_misses();
        rv32i_word data_a;
        rv32i_word data_b;
        logic done_a;
        logic done_b;
        int cycles;
        @(posedge clk);
        #1;
        req_a = '0;
        req_a.read = 1'b1;
        req_a.addr = 32'h0000_3004;
        req_b = '0;
        req_b.read = 1'b1;
        req_b.addr = 32'h0000_4064;
        done_a = 1'b0;
        done_b = 1'b0;
        cycles = 0;
        while (!(done_a && done_b) && cycles < timeout) begin
                @(posedge clk);
                #1;
                cycles++;
                assert (!(pmem_req.read && pmem_req.write))
                else report_fail("pmem_req showed read and write in the same cycle");
                // a finished port drops one cycle after its resp
                if (done_a) begin
                        req_a = '0;
                end
                if (done_b) begin
                        req_b = '0;
                end
                if (rsp_a.resp) begin
                        data_a = rsp_a.rdata;
                        done_a = 1'b1;
                end
                if (rsp_b.resp) begin
                        data_b = rsp_b.rdata;
                        done_b = 1'b1;
                end
        end
        assert (done_a && done_b)
        else report_fail("simultaneous port A and port B misses did not both complete");
        @(posedge clk);
        #1;
        req_a = '0;
        req_b = '0;
        check_word("rsp_a.rdata", ref_read(32'h0000_3004), data_a);
        check_word("rsp_b.rdata", ref_read(32'h0000_4064), data_b);
endtask

// a window store pulses the matching branch reset and no other
task automatic store_branch_reset(input perf_sel_e sel);
        rv32i_word data;
        int total_before;
        int correct_before;
        int incorrect_before;
        total_before = total_pulses;
        correct_before = correct_pulses;
        incorrect_before = incorrect_pulses;
        data_access(1'b1, window_addr(sel), 4'hf, '0, data);
        @(posedge clk);
        #1;
        check_word("branch_total_reset cycles", (sel == perf_branch_total) ? 32'd1 : 32'd0,
                   32'(total_pulses - total_before));
        check_word("branch_correct_reset cycles", (sel == perf_branch_correct) ? 32'd1 : 32'd0,
                   32'(correct_pulses - correct_before));
        check_word("branch_incorrect_reset cycles",
                   (sel == perf_branch_incorrect) ? 32'd1 : 32'd0,
                   32'(incorrect_pulses - incorrect_before));
endtask

task automatic counter_window();
        rv32i_word data;
        data_access(1'b0, window_addr(perf_branch_correct), 4'h0, '0, data);
        check_word("branch_correct read", branch_correct_count, data);
        store_branch_reset(perf_branch_total);
        store_branch_reset(perf_branch_correct);
        store_branch_reset(perf_branch_incorrect);
        data_access(1'b1, window_addr(perf_dcache_miss), 4'hf, '0, data);
        data_access(1'b0, window_addr(perf_dcache_miss), 4'h0, '0, data);
        check_word("dcache_miss count", 32'd0, data);
endtask

initial begin
        seed = 32'h3383_3b12;
        reset = 1'b1;
        req_a = '0;
        req_b = '0;
        branch_total_count = 32'h0000_0311;
        branch_correct_count = 32'h0000_02c5;
        branch_incorrect_count = 32'h0000_004c;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        fetch_hit_after_miss();
        masked_store_readback();
        evict_dirty_line();
        concurrent_misses();
        counter_window();

        $display("Simulation completed successfully");
        $finish;
end

endmodule : tb_mem_hierarchy
